// File: verilog.f
+incdir+verif
src/board_pkg.sv
src/board_reset.sv
src/board_inputs.sv
src/status_led.sv
src/video_expand.sv
src/board_top.sv
verif/board_tb.sv

// File: Makefile
# Verilator build and run of the board glue testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= board_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/board_tb_vectors.svh
// stimulus rows with cycle counts and expected outputs for the board testbench
// column order is name, kind, cycles, ctl, kjoy, bjoy, slot, flags, lamp, vctl, rgb, expected
// ctl {rst_req,pll_locked,dwnld_busy,ioctl_wr,ioctl_cart}
// vctl {pxl_cen,LHBL,LVBL,hs,vs}
// kjoy and bjoy {joy2,joy1}
// slot {key_start,key_coin,board_start,board_coin}
// flags {key_service,board_service,key_tilt,board_tilt,key_reset,board_reset}
// lamp {osd_shown,game_led} and rgb {r,g,b}
// frame rows count frames instead of cycles
add_row("reset hold", K_IO, 16, 'h08, 'h1, 'h0, 'h1000, 'h20, 'h0, 'h0C, 'h000, 'h7FFFFFFF);
add_row("reset release", K_IO, 1, 'h08, 'h1, 'h0, 'h1000, 'h20, 'h0, 'h0C, 'h000, 'h3FFFFFFF);
add_row("joy merge", K_IO, 1, 'h08, 'h1, 'h80, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h3FFFFFFE);
add_row("joy mask", K_IO, 1, 'h08, 'hC00, 'h13F0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h3FFFE3CF);
add_row("slot merge", K_IO, 1, 'h08, 'h0, 'h0, 'h2418, 'h18, 'h0, 'h0C, 'h000, 'h0C3FFFFF);
add_row("flag merge", K_IO, 1, 'h08, 'h0, 'h0, 'h0, 'h24, 'h0, 'h0C, 'h000, 'h0FFFFFFF);
add_row("inputs idle", K_IO, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h3FFFFFFF);
add_row("key reset", K_IO, 1, 'h08, 'h0, 'h0, 'h0, 'h02, 'h0, 'h0C, 'h000, 'h3FFFFFFF);
add_row("key reset hold", K_IO, 17, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h7FFFFFFF);
add_row("key reset end", K_IO, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h3FFFFFFF);
add_row("dl cart write", K_IO, 4, 'h0F, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h3FFFFFFF);
add_row("dl rom write", K_IO, 1, 'h0E, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h3FFFFFFF);
add_row("dl rom hold", K_IO, 20, 'h0C, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h7FFFFFFF);
add_row("dl end hold", K_IO, 17, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h7FFFFFFF);
add_row("dl end", K_IO, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h3FFFFFFF);
add_row("led game", K_LED, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h1, 'h0C, 'h000, 'h1);
add_row("led game off", K_LED, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h0);
add_row("led osd", K_LED, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h2, 'h0C, 'h000, 'h1);
add_row("led osd over dl", K_LED, 1, 'h0C, 'h0, 'h0, 'h0, 'h00, 'h2, 'h0C, 'h000, 'h1);
add_row("led dl start", K_LED, 1, 'h0C, 'h0, 'h0, 'h0, 'h00, 'h1, 'h0C, 'h000, 'h0);
add_row("blink 3 frames", K_FRAME, 3, 'h0C, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h0);
add_row("blink toggle", K_FRAME, 1, 'h0C, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h1);
add_row("blink 4 frames", K_FRAME, 4, 'h0C, 'h0, 'h0, 'h0, 'h00, 'h0, 'h0C, 'h000, 'h0);
add_row("led dl end", K_LED, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h1, 'h0C, 'h000, 'h1);
add_row("colour widen", K_VID, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h1C, 'hA3C, 'h1AA33CC);
add_row("colour hold", K_VID, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h03, 'h5F1, 'h1AA33CC);
add_row("de vblank", K_VID, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h1A, 'h5F1, 'h455FF11);
add_row("de hblank", K_VID, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h14, 'h000, 'h0000000);
add_row("de active", K_VID, 1, 'h08, 'h0, 'h0, 'h0, 'h00, 'h0, 'h1C, 'h7E9, 'h177EE99);

// File: verif/board_tb.sv
// board_tb: clock, reset, table-driven stimulus, output checks and report
`timescale 1ns/1ps
`default_nettype none

module board_tb;

    // row kinds select which outputs are compared
    localparam int K_IO    = 0;
    localparam int K_LED   = 1;
    localparam int K_FRAME = 2;
    localparam int K_VID   = 3;

    typedef struct packed {
        logic [4:0]  ctl;
        logic [19:0] kjoy;
        logic [19:0] bjoy;
        logic [15:0] slot;
        logic [5:0]  flags;
        logic [1:0]  lamp;
        logic [4:0]  vctl;
        logic [11:0] rgb;
    } stim_t;

    string       name_q[$];
    int          kind_q[$];
    int          cyc_q[$];
    stim_t       stim_q[$];
    logic [31:0] exp_q[$];

    logic              clk_rom;
    logic              reset;
    logic              rst_req, pll_locked, dwnld_busy, ioctl_wr, ioctl_cart;
    logic              game_rst;
    board_pkg::joy_t   key_joy1, key_joy2, board_joy1, board_joy2;
    board_pkg::joy_t   game_joy1, game_joy2;
    board_pkg::slot_t  key_start, key_coin, board_start, board_coin;
    board_pkg::slot_t  game_start, game_coin;
    logic              key_service, board_service, key_tilt, board_tilt;
    logic              key_reset, board_reset;
    logic              game_service, game_tilt;
    logic              osd_shown, game_led, led;
    logic              pxl_cen, LHBL, LVBL, hs, vs;
    logic [3:0]        game_r, game_g, game_b;
    board_pkg::chan8_t base_r, base_g, base_b;
    logic              base_hs, base_vs, base_de;

    int cycle_cnt = 0;
    int pass_cnt  = 0;
    int fail_cnt  = 0;

    board_top dut (.*);

    initial begin
        clk_rom = 1'b0;
        forever #20 clk_rom = ~clk_rom;
    end

    // run limit grows with the table
    always @(posedge clk_rom) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > 64 * name_q.size() + 100) begin
            $display("timeout: run exceeded %0d clock cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_row(input string name, input int kind, input int cyc,
                           input logic [31:0] ctl, input logic [31:0] kjoy,
                           input logic [31:0] bjoy, input logic [31:0] slot,
                           input logic [31:0] flags, input logic [31:0] lamp,
                           input logic [31:0] vctl, input logic [31:0] rgb,
                           input logic [31:0] exp);
        stim_t s;
        s = {ctl[4:0], kjoy[19:0], bjoy[19:0], slot[15:0], flags[5:0], lamp[1:0],
             vctl[4:0], rgb[11:0]};
        name_q.push_back(name);
        kind_q.push_back(kind);
        cyc_q.push_back(cyc);
        stim_q.push_back(s);
        exp_q.push_back(exp);
    endtask

    task automatic load_table();
        `include "board_tb_vectors.svh"
    endtask

    task automatic drive_inputs(input stim_t s);
        {rst_req, pll_locked, dwnld_busy, ioctl_wr, ioctl_cart} = s.ctl;
        {key_joy2, key_joy1} = s.kjoy;
        {board_joy2, board_joy1} = s.bjoy;
        {key_start, key_coin, board_start, board_coin} = s.slot;
        {key_service, board_service, key_tilt, board_tilt, key_reset, board_reset} = s.flags;
        {osd_shown, game_led} = s.lamp;
        {pxl_cen, LHBL, LVBL, hs, vs} = s.vctl;
        {game_r, game_g, game_b} = s.rgb;
    endtask

    // frame rows spend one cycle in vertical blank and one out of it
    task automatic run_cycles(input int n, input int kind);
        int i;
        for (i = 0; i < n; i++) begin
            if (kind == K_FRAME) begin
                LVBL = 1'b0;
                @(posedge clk_rom);
                #2;
                LVBL = 1'b1;
            end
            @(posedge clk_rom);
            #2;
        end
    endtask

    // io {0,rst,service,tilt,start,coin,joy2,joy1}, video {0,hs,vs,de,r,g,b}
    function automatic logic [31:0] observe(input int kind);
        logic [31:0] v;
        case (kind)
            K_IO:    v = {1'b0, game_rst, game_service, game_tilt, game_start, game_coin,
                          game_joy2, game_joy1};
            K_VID:   v = {5'b0, base_hs, base_vs, base_de, base_r, base_g, base_b};
            default: v = {31'b0, led};
        endcase
        return v;
    endfunction

    initial begin
        int          r;
        logic [31:0] got;
        stim_t       idle;
        // pll locked, both blanking inputs inactive
        idle      = '0;
        idle.ctl  = 5'b01000;
        idle.vctl = 5'b01100;
        reset     = 1'b1;
        drive_inputs(idle);
        load_table();
        repeat (8) @(posedge clk_rom);
        #2;
        reset = 1'b0;
        for (r = 0; r < name_q.size(); r++) begin
            drive_inputs(stim_q[r]);
            run_cycles(cyc_q[r], kind_q[r]);
            got = observe(kind_q[r]);
            if (got !== exp_q[r]) begin
                $display("FAIL %s expected %h actual %h", name_q[r], exp_q[r], got);
                fail_cnt++;
            end else begin
                $display("PASS %s", name_q[r]);
                pass_cnt++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed", name_q.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/board_top.sv
// board_top: reset, input merge, status LED and video widening units
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int COLORW       = 4,
    parameter int BUTTONS      = 2,
    parameter int ACTIVE_LOW   = 1,
    parameter int RST_CYCLES   = 16,
    parameter int BLINK_FRAMES = 4
) (
    input  logic               clk_rom,
    input  logic               reset,
    // reset causes
    input  logic               rst_req,
    input  logic               pll_locked,
    input  logic               dwnld_busy,
    input  logic               ioctl_wr,
    input  logic               ioctl_cart,
    output logic               game_rst,
    // player controls
    input  board_pkg::joy_t    key_joy1,
    input  board_pkg::joy_t    key_joy2,
    input  board_pkg::joy_t    board_joy1,
    input  board_pkg::joy_t    board_joy2,
    input  board_pkg::slot_t   key_start,
    input  board_pkg::slot_t   key_coin,
    input  board_pkg::slot_t   board_start,
    input  board_pkg::slot_t   board_coin,
    input  logic               key_service,
    input  logic               board_service,
    input  logic               key_tilt,
    input  logic               board_tilt,
    input  logic               key_reset,
    input  logic               board_reset,
    output board_pkg::joy_t    game_joy1,
    output board_pkg::joy_t    game_joy2,
    output board_pkg::slot_t   game_start,
    output board_pkg::slot_t   game_coin,
    output logic               game_service,
    output logic               game_tilt,
    // status led
    input  logic               osd_shown,
    input  logic               game_led,
    output logic               led,
    // video
    input  logic               pxl_cen,
    input  logic [COLORW-1:0]  game_r,
    input  logic [COLORW-1:0]  game_g,
    input  logic [COLORW-1:0]  game_b,
    input  logic               LHBL,
    input  logic               LVBL,
    input  logic               hs,
    input  logic               vs,
    output board_pkg::chan8_t  base_r,
    output board_pkg::chan8_t  base_g,
    output board_pkg::chan8_t  base_b,
    output logic               base_hs,
    output logic               base_vs,
    output logic               base_de
);

    // reset key path back into the sequencer
    logic soft_rst;

    board_reset #(
        .RST_CYCLES ( RST_CYCLES )
    ) u_reset (
        .clk_rom    ( clk_rom    ),
        .reset      ( reset      ),
        .rst_req    ( rst_req    ),
        .pll_locked ( pll_locked ),
        .soft_rst   ( soft_rst   ),
        .dwnld_busy ( dwnld_busy ),
        .ioctl_wr   ( ioctl_wr   ),
        .ioctl_cart ( ioctl_cart ),
        .game_rst   ( game_rst   )
    );

    board_inputs #(
        .BUTTONS       ( BUTTONS       ),
        .ACTIVE_LOW    ( ACTIVE_LOW    )
    ) u_inputs (
        .clk_rom       ( clk_rom       ),
        .reset         ( reset         ),
        .game_rst      ( game_rst      ),
        .key_joy1      ( key_joy1      ),
        .key_joy2      ( key_joy2      ),
        .board_joy1    ( board_joy1    ),
        .board_joy2    ( board_joy2    ),
        .key_start     ( key_start     ),
        .key_coin      ( key_coin      ),
        .board_start   ( board_start   ),
        .board_coin    ( board_coin    ),
        .key_service   ( key_service   ),
        .board_service ( board_service ),
        .key_tilt      ( key_tilt      ),
        .board_tilt    ( board_tilt    ),
        .key_reset     ( key_reset     ),
        .board_reset   ( board_reset   ),
        .game_joy1     ( game_joy1     ),
        .game_joy2     ( game_joy2     ),
        .game_start    ( game_start    ),
        .game_coin     ( game_coin     ),
        .game_service  ( game_service  ),
        .game_tilt     ( game_tilt     ),
        .soft_rst      ( soft_rst      )
    );

    status_led #(
        .BLINK_FRAMES ( BLINK_FRAMES )
    ) u_led (
        .clk_rom      ( clk_rom      ),
        .reset        ( reset        ),
        .LVBL         ( LVBL         ),
        .dwnld_busy   ( dwnld_busy   ),
        .osd_shown    ( osd_shown    ),
        .game_led     ( game_led     ),
        .led          ( led          )
    );

    video_expand #(
        .COLORW  ( COLORW  )
    ) u_video (
        .clk_rom ( clk_rom ),
        .reset   ( reset   ),
        .pxl_cen ( pxl_cen ),
        .game_r  ( game_r  ),
        .game_g  ( game_g  ),
        .game_b  ( game_b  ),
        .LHBL    ( LHBL    ),
        .LVBL    ( LVBL    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .base_r  ( base_r  ),
        .base_g  ( base_g  ),
        .base_b  ( base_b  ),
        .base_hs ( base_hs ),
        .base_vs ( base_vs ),
        .base_de ( base_de )
    );

endmodule

`default_nettype wire

// File: src/video_expand.sv
// video_expand: colour replication to eight bits, sync delay and display enable
`timescale 1ns/1ps
`default_nettype none

module video_expand #(
    parameter int COLORW = 4
) (
    input  logic               clk_rom,
    input  logic               reset,
    input  logic               pxl_cen,
    input  logic [COLORW-1:0]  game_r,
    input  logic [COLORW-1:0]  game_g,
    input  logic [COLORW-1:0]  game_b,
    input  logic               LHBL,
    input  logic               LVBL,
    input  logic               hs,
    input  logic               vs,
    output board_pkg::chan8_t  base_r,
    output board_pkg::chan8_t  base_g,
    output board_pkg::chan8_t  base_b,
    output logic               base_hs,
    output logic               base_vs,
    output logic               base_de
);

    // repeat the channel from its msb until eight bits are filled
    function automatic board_pkg::chan8_t widen(input logic [COLORW-1:0] c);
        board_pkg::chan8_t w;
        int                k;
        for (k = 0; k < board_pkg::CHAN8_W; k++) begin
            w[board_pkg::CHAN8_W-1-k] = c[COLORW-1-(k % COLORW)];
        end
        return w;
    endfunction

    // widened colour payload
    always_ff @(posedge clk_rom) begin
        if (pxl_cen) begin
            base_r <= widen(game_r);
            base_g <= widen(game_g);
            base_b <= widen(game_b);
        end
    end

    always_ff @(posedge clk_rom) begin
        if (reset) begin
            base_hs <= 1'b0;
            base_vs <= 1'b0;
            base_de <= 1'b0;
        end else if (pxl_cen) begin
            base_hs <= hs;
            base_vs <= vs;
            // blanking inputs are active low
            base_de <= LHBL & LVBL;
        end
    end

    // enable only moves with the pixel clock enable
    a_de_on_cen: assert property (@(posedge clk_rom) disable iff (reset)
        $rose(base_de) |-> $past(pxl_cen))
        else $error("base_de rose without pxl_cen");

endmodule

`default_nettype wire

// File: src/status_led.sv
// status_led: frame-counted download blink and LED source priority
`timescale 1ns/1ps
`default_nettype none

module status_led #(
    parameter int BLINK_FRAMES = 4
) (
    input  logic clk_rom,
    input  logic reset,
    input  logic LVBL,
    input  logic dwnld_busy,
    input  logic osd_shown,
    input  logic game_led,
    output logic led
);

    localparam int FW = (BLINK_FRAMES > 1) ? $clog2(BLINK_FRAMES) : 1;
    localparam logic [FW-1:0] LAST_FRAME = FW'(BLINK_FRAMES - 1);

    logic          lvbl_l;
    logic          frame_start;
    logic [FW-1:0] frame_cnt;
    logic          blink;

    // falling LVBL marks the start of vertical blank
    assign frame_start = lvbl_l & ~LVBL;

    always_ff @(posedge clk_rom) begin
        if (reset) begin
            lvbl_l    <= 1'b0;
            frame_cnt <= '0;
            blink     <= 1'b0;
        end else begin
            lvbl_l <= LVBL;
            if (!dwnld_busy) begin
                frame_cnt <= '0;
                blink     <= 1'b0;
            end else if (frame_start) begin
                if (frame_cnt == LAST_FRAME) begin
                    frame_cnt <= '0;
                    blink     <= ~blink;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    // osd first, then download, then the game
    always_ff @(posedge clk_rom) begin
        if (reset) begin
            led <= 1'b0;
        end else if (osd_shown) begin
            led <= 1'b1;
        end else if (dwnld_busy) begin
            led <= blink;
        end else begin
            led <= game_led;
        end
    end

endmodule

`default_nettype wire

// File: src/board_inputs.sv
// board_inputs: keyboard and board control merge, button masking and game polarity
`timescale 1ns/1ps
`default_nettype none

module board_inputs #(
    parameter int BUTTONS    = 2,
    parameter int ACTIVE_LOW = 1
) (
    input  logic              clk_rom,
    input  logic              reset,
    input  logic              game_rst,
    input  board_pkg::joy_t   key_joy1,
    input  board_pkg::joy_t   key_joy2,
    input  board_pkg::joy_t   board_joy1,
    input  board_pkg::joy_t   board_joy2,
    input  board_pkg::slot_t  key_start,
    input  board_pkg::slot_t  key_coin,
    input  board_pkg::slot_t  board_start,
    input  board_pkg::slot_t  board_coin,
    input  logic              key_service,
    input  logic              board_service,
    input  logic              key_tilt,
    input  logic              board_tilt,
    input  logic              key_reset,
    input  logic              board_reset,
    output board_pkg::joy_t   game_joy1,
    output board_pkg::joy_t   game_joy2,
    output board_pkg::slot_t  game_start,
    output board_pkg::slot_t  game_coin,
    output logic              game_service,
    output logic              game_tilt,
    output logic              soft_rst
);

    localparam logic INV = (ACTIVE_LOW != 0);

    // directions plus the buttons the game actually reads
    localparam board_pkg::joy_t JOY_MASK =
        board_pkg::joy_t'((1 << (board_pkg::DIR_W + BUTTONS)) - 1);

    localparam board_pkg::joy_t  JOY_INV  = {board_pkg::JOY_W{INV}};
    localparam board_pkg::slot_t SLOT_INV = {board_pkg::SLOT_W{INV}};

    board_pkg::joy_t joy1_act;
    board_pkg::joy_t joy2_act;

    // active-high merge before polarity
    assign joy1_act = (key_joy1 | board_joy1) & JOY_MASK;
    assign joy2_act = (key_joy2 | board_joy2) & JOY_MASK;

    always_ff @(posedge clk_rom) begin
        if (reset || game_rst) begin
            game_joy1    <= JOY_INV;
            game_joy2    <= JOY_INV;
            game_start   <= SLOT_INV;
            game_coin    <= SLOT_INV;
            game_service <= INV;
            game_tilt    <= INV;
            soft_rst     <= 1'b0;
        end else begin
            game_joy1    <= joy1_act ^ JOY_INV;
            game_joy2    <= joy2_act ^ JOY_INV;
            game_start   <= (key_start | board_start) ^ SLOT_INV;
            game_coin    <= (key_coin | board_coin) ^ SLOT_INV;
            game_service <= (key_service | board_service) ^ INV;
            game_tilt    <= (key_tilt | board_tilt) ^ INV;
            soft_rst     <= key_reset | board_reset;
        end
    end

    // button count has to fit above the direction bits
    a_buttons_range: assert property (@(posedge clk_rom)
        BUTTONS >= 1 && BUTTONS <= board_pkg::JOY_W - board_pkg::DIR_W)
        else $error("BUTTONS out of range: %0d", BUTTONS);

endmodule

`default_nettype wire

// File: src/board_reset.sv
// board_reset: ROM download reset latch and game reset stretch counter
`timescale 1ns/1ps
`default_nettype none

module board_reset #(
    parameter int RST_CYCLES = 16
) (
    input  logic clk_rom,
    input  logic reset,
    input  logic rst_req,
    input  logic pll_locked,
    input  logic soft_rst,
    input  logic dwnld_busy,
    input  logic ioctl_wr,
    input  logic ioctl_cart,
    output logic game_rst
);

    localparam int CW = $clog2(RST_CYCLES + 1);
    localparam logic [CW-1:0] CNT_LOAD = CW'(RST_CYCLES);

    logic          rom_rst;
    logic [CW-1:0] rst_cnt;
    logic          rst_cause;

    // any of these restarts the stretch
    assign rst_cause = reset | rst_req | ~pll_locked | soft_rst | rom_rst;

    // writes outside a cartridge load keep the game in reset
    always_ff @(posedge clk_rom) begin
        if (reset) begin
            rom_rst <= 1'b0;
        end else if (!dwnld_busy) begin
            rom_rst <= 1'b0;
        end else if (ioctl_wr && !ioctl_cart) begin
            rom_rst <= 1'b1;
        end
    end

    always_ff @(posedge clk_rom) begin
        if (reset) begin
            rst_cnt  <= CNT_LOAD;
            game_rst <= 1'b1;
        end else begin
            if (rst_cause) begin
                rst_cnt <= CNT_LOAD;
            end else if (rst_cnt != '0) begin
                rst_cnt <= rst_cnt - 1'b1;
            end
            // one cycle behind the counter
            game_rst <= (rst_cnt != '0);
        end
    end

    // system reset always reaches the game side
    a_reset_to_game: assert property (@(posedge clk_rom) reset |=> game_rst)
        else $error("game_rst low on the cycle after reset");

endmodule

`default_nettype wire

// File: src/board_pkg.sv
// shared widths and word types for the arcade board glue block
`default_nettype none

package board_pkg;

    // joystick word, directions in the low bits and buttons above
    localparam int JOY_W = 10;
    localparam int DIR_W = 4;

    // one bit per player slot in the start and coin words
    localparam int SLOT_W = 4;

    // colour channel width after widening
    localparam int CHAN8_W = 8;

    typedef logic [JOY_W-1:0]   joy_t;
    typedef logic [SLOT_W-1:0]  slot_t;
    typedef logic [CHAN8_W-1:0] chan8_t;

endpackage

`default_nettype wire
